// ==== rtl/qa7_pkg.sv ====
//////////////////////////////////////////////////
// qa7 housekeeping package
// timing constants and shared display types
//////////////////////////////////////////////////
`default_nettype none

package qa7_pkg;

   // 50 MHz board oscillator
   localparam int CLK_PER_US = 50;     // sys_clk_p cycles per us strobe
   localparam int US_PER_MS  = 1000;   // us strobes per ms strobe

   // reset stretch after the board reset drops
   localparam int POR_CYCLES = 16;

   // equal ms samples needed before a button level is accepted
   localparam int DEB_MS     = 2;

   // seven segment display
   localparam int DIGITS     = 3;      // physical digits
   localparam int SCAN_LAST  = 5;      // states 3..5 are blank slots

   // scan state, 0..SCAN_LAST
   typedef logic [2:0] hsel_t;

   // segment pattern, bit 0 = a ... bit 6 = g, bit 7 = dp
   // active high inside the design
   typedef logic [7:0] seg_t;

endpackage

`default_nettype wire

// ==== rtl/sys_bus_if.sv ====
//////////////////////////////////////////////////
// system bus bundle
// clock, resets and timebase strobes
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

interface sys_bus_if
(
   input wire logic sys_clk_p          // 50 MHz system clock
);

   logic pwr_rst;                      // power-on reset, level
   logic sys_rst;                      // system reset, level
   logic ena_us;                       // microsecond strobe, one cycle
   logic ena_ms;                       // millisecond strobe, one cycle

   // reset controller side
   modport rst_src (input sys_clk_p, output pwr_rst, output sys_rst);

   // timebase side, held in reset by sys_rst
   modport tick_src (input sys_clk_p, input sys_rst, output ena_us, output ena_ms);

   // consumers
   modport user
   (
      input sys_clk_p,
      input pwr_rst,
      input sys_rst,
      input ena_us,
      input ena_ms
   );

endinterface

`default_nettype wire

// ==== rtl/reset_ctl.sv ====
//////////////////////////////////////////////////
// reset controller
// stretches board reset into pwr_rst and adds
// the synchronized reset button into sys_rst
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module reset_ctl
(
   input  wire logic    reset,         // board reset, sync, active high
   input  wire logic    button_n,      // reset button, async, active low
   sys_bus_if.rst_src   sys
);

   logic [$clog2(qa7_pkg::POR_CYCLES)-1:0] por_cnt;   // cycles left in stretch
   logic                                   btn_meta;  // first sync stage

   // power-on stretcher
   always_ff @(posedge sys.sys_clk_p)
   begin
      if (reset)
      begin
         por_cnt     <= ($clog2(qa7_pkg::POR_CYCLES))'(qa7_pkg::POR_CYCLES - 1);
         sys.pwr_rst <= 1'b1;
      end
      else if (por_cnt != '0)
      begin
         por_cnt     <= por_cnt - 1'b1;   // still counting down
         sys.pwr_rst <= 1'b1;
      end
      else
         sys.pwr_rst <= 1'b0;             // stretch done
   end

   // button path, sys_rst itself is the second sync stage
   always_ff @(posedge sys.sys_clk_p)
   begin
      if (reset)
      begin
         btn_meta    <= 1'b1;             // released
         sys.sys_rst <= 1'b1;
      end
      else
      begin
         btn_meta    <= button_n;
         sys.sys_rst <= sys.pwr_rst | ~btn_meta;   // pressed or still in por
      end
   end

endmodule

`default_nettype wire

// ==== rtl/tick_gen.sv ====
//////////////////////////////////////////////////
// timebase
// microsecond and millisecond strobes from the
// 50 MHz system clock
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tick_gen
(
   sys_bus_if.tick_src  sys
);

   logic [$clog2(qa7_pkg::CLK_PER_US)-1:0] us_cnt;    // cycle prescaler
   logic [$clog2(qa7_pkg::US_PER_MS)-1:0]  ms_cnt;    // us strobe counter
   logic                                   us_wrap;   // prescaler at last cycle

   assign us_wrap = (us_cnt == ($clog2(qa7_pkg::CLK_PER_US))'(qa7_pkg::CLK_PER_US - 1));

   always_ff @(posedge sys.sys_clk_p)
   begin
      if (sys.sys_rst)
      begin
         us_cnt     <= '0;
         ms_cnt     <= '0;
         sys.ena_us <= 1'b0;
         sys.ena_ms <= 1'b0;
      end
      else if (us_wrap)
      begin
         us_cnt     <= '0;
         sys.ena_us <= 1'b1;              // one us elapsed
         if (ms_cnt == ($clog2(qa7_pkg::US_PER_MS))'(qa7_pkg::US_PER_MS - 1))
         begin
            ms_cnt     <= '0;
            sys.ena_ms <= 1'b1;           // same cycle as the us strobe
         end
         else
         begin
            ms_cnt     <= ms_cnt + 1'b1;
            sys.ena_ms <= 1'b0;
         end
      end
      else
      begin
         us_cnt     <= us_cnt + 1'b1;
         sys.ena_us <= 1'b0;              // strobes last one cycle
         sys.ena_ms <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/button_toggle.sv ====
//////////////////////////////////////////////////
// button toggle
// debounces a push button on the ms strobe and
// flips its output level on every press
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module button_toggle
(
   sys_bus_if.user      sys,
   input  wire logic    button_n,      // push button, async, active low
   output logic         level          // toggled level
);

   logic                                 sync_0;    // first sync stage
   logic                                 sync_1;    // second sync stage
   logic                                 pressed;   // debounced state, 1 = held
   logic [$clog2(qa7_pkg::DEB_MS+1)-1:0] deb_cnt;   // samples differing from state
   logic                                 sample;    // current sample, 1 = low pin

   assign sample = ~sync_1;

   always_ff @(posedge sys.sys_clk_p)
   begin
      if (sys.pwr_rst)
      begin
         sync_0  <= 1'b1;
         sync_1  <= 1'b1;
         pressed <= 1'b0;
         deb_cnt <= '0;
         level   <= 1'b0;
      end
      else
      begin
         sync_0 <= button_n;
         sync_1 <= sync_0;
         if (sys.ena_ms)                  // one sample per millisecond
         begin
            if (sample == pressed)
               deb_cnt <= '0;             // glitch gone, start over
            else if (deb_cnt == ($clog2(qa7_pkg::DEB_MS+1))'(qa7_pkg::DEB_MS - 1))
            begin
               deb_cnt <= '0;
               pressed <= sample;         // new level accepted
               if (sample)
                  level <= ~level;        // only a press flips the output
            end
            else
               deb_cnt <= deb_cnt + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== rtl/seg_scan.sv ====
//////////////////////////////////////////////////
// seven segment scan
// steps the digit select on the ms strobe and
// decodes the selected nibble to hex segments
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module seg_scan
(
   sys_bus_if.user                              sys,
   input  wire logic [4*qa7_pkg::DIGITS-1:0]    hex_value,  // digit 0 in [3:0]
   output qa7_pkg::seg_t                        hex,        // segments, active low
   output logic [qa7_pkg::DIGITS-1:0]           hsel        // digit select, active low
);

   qa7_pkg::hsel_t   state;            // scan state
   logic [3:0]       nibble;           // selected digit value
   qa7_pkg::seg_t    seg;              // decoded pattern, active high

   // scan runs down, 0 wraps to the last blank slot
   always_ff @(posedge sys.sys_clk_p)
   begin
      if (sys.sys_rst)
         state <= '0;
      else if (sys.ena_ms)
      begin
         if (state == '0)
            state <= qa7_pkg::hsel_t'(qa7_pkg::SCAN_LAST);
         else
            state <= state - 1'b1;
      end
   end

   always_comb
   begin
      nibble = '0;
      hsel   = '1;                        // all digits off
      for (int i = 0; i < qa7_pkg::DIGITS; i++)
      begin
         if (state == qa7_pkg::hsel_t'(i))
         begin
            nibble  = hex_value[4*i +: 4];
            hsel[i] = 1'b0;
         end
      end
   end

   // standard hex font, a in bit 0, dp off
   always_comb
   begin
      case (nibble)
         4'h0: seg = 8'h3F;
         4'h1: seg = 8'h06;
         4'h2: seg = 8'h5B;
         4'h3: seg = 8'h4F;
         4'h4: seg = 8'h66;
         4'h5: seg = 8'h6D;
         4'h6: seg = 8'h7D;
         4'h7: seg = 8'h07;
         4'h8: seg = 8'h7F;
         4'h9: seg = 8'h6F;
         4'hA: seg = 8'h77;
         4'hB: seg = 8'h7C;               // lower case b
         4'hC: seg = 8'h39;
         4'hD: seg = 8'h5E;               // lower case d
         4'hE: seg = 8'h79;
         default: seg = 8'h71;            // F
      endcase
   end

   // blank slots drive every segment off
   assign hex = (state < qa7_pkg::hsel_t'(qa7_pkg::DIGITS)) ? ~seg : 8'hFF;

endmodule

`default_nettype wire

// ==== rtl/qa7_top.sv ====
//////////////////////////////////////////////////
// qa7 board top level
// resets, timebase, button toggles and the
// seven segment display scan
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module qa7_top
(
   input  wire logic                            sys_clk_p,  // 50 MHz clock
   input  wire logic                            reset,      // sync, active high
   input  wire logic [2:0]                      button,     // push buttons, active low
   input  wire logic [4*qa7_pkg::DIGITS-1:0]    hex_value,  // value shown on display
                                                            //
   output logic [1:0]                           led,        // toggle outputs
   output qa7_pkg::seg_t                        hex,        // segment mask, active low
   output logic [qa7_pkg::DIGITS-1:0]           hsel,       // digit select, active low
   output logic                                 us_tick,    // us strobe to gpio
   output logic                                 ms_tick     // ms strobe to gpio
);

   // clock, resets and strobes shared by all blocks
   sys_bus_if sys (.sys_clk_p(sys_clk_p));

   // button 0 is the system reset button
   reset_ctl u_reset
   (
      .reset    (reset),
      .button_n (button[0]),
      .sys      (sys.rst_src)
   );

   // us and ms strobes
   tick_gen u_tick
   (
      .sys (sys.tick_src)
   );

   // button 1 toggles the timer enable
   button_toggle u_tog1
   (
      .sys      (sys.user),
      .button_n (button[1]),
      .level    (led[0])
   );

   // button 2 toggles the slow enable
   button_toggle u_tog2
   (
      .sys      (sys.user),
      .button_n (button[2]),
      .level    (led[1])
   );

   // display scan and hex decode
   seg_scan u_scan
   (
      .sys       (sys.user),
      .hex_value (hex_value),
      .hex       (hex),
      .hsel      (hsel)
   );

   // strobes brought out for a scope
   assign us_tick = sys.ena_us;
   assign ms_tick = sys.ena_ms;

endmodule

`default_nettype wire

// ==== dv/tb_qa7_top.sv ====
//////////////////////////////////////////////////
// qa7 top level testbench
// resets, strobe spacing, display scan table,
// button toggles and the reset button
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_qa7_top;

   localparam int NUM_ENTRIES = 7;                   // 3 fixed + 4 random
   localparam int MS_CYCLES   = qa7_pkg::CLK_PER_US * qa7_pkg::US_PER_MS;

   logic             sys_clk_p;
   logic             reset;
   logic [2:0]       button;                         // active low
   logic [11:0]      hex_value;
   logic [1:0]       led;
   qa7_pkg::seg_t    hex;
   logic [2:0]       hsel;
   logic             us_tick;
   logic             ms_tick;

   // hex font, a in bit 0, dp off
   qa7_pkg::seg_t    font [16] = '{8'h3F, 8'h06, 8'h5B, 8'h4F, 8'h66, 8'h6D, 8'h7D, 8'h07,
                                   8'h7F, 8'h6F, 8'h77, 8'h7C, 8'h39, 8'h5E, 8'h79, 8'h71};
   logic [11:0]      tab_val [NUM_ENTRIES];          // stimulus
   qa7_pkg::seg_t    tab_seg [NUM_ENTRIES][3];       // expected pattern per digit
   qa7_pkg::hsel_t   scan_exp = '0;                  // model of the scan state
   int unsigned      seed = 32'h5a77f1c2;
   int               n;                              // measured cycle count

   qa7_top DUT
   (
      .sys_clk_p (sys_clk_p),
      .reset     (reset),
      .button    (button),
      .hex_value (hex_value),
      .led       (led),
      .hex       (hex),
      .hsel      (hsel),
      .us_tick   (us_tick),
      .ms_tick   (ms_tick)
   );

   always #20 sys_clk_p = ~sys_clk_p;               // 25 MHz sim clock, 40 ns

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("STATUS: FAIL");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_seg(input string name, qa7_pkg::seg_t exp, qa7_pkg::seg_t act);
      if (act !== exp)
         abort_run($sformatf("FAILED %s expected %h actual %h", name, exp, act));
   endtask

   task automatic check_sel(input string name, logic [2:0] exp, logic [2:0] act);
      if (act !== exp)
         abort_run($sformatf("FAILED %s expected %b actual %b", name, exp, act));
   endtask

   task automatic check_led(input string name, logic [1:0] exp, logic [1:0] act);
      if (act !== exp)
         abort_run($sformatf("FAILED %s expected %b actual %b", name, exp, act));
   endtask

   task automatic check_count(input string name, int exp, int act, int tol);
      if (act < exp - tol || act > exp + tol)
         abort_run($sformatf("FAILED %s expected %0d actual %0d", name, exp, act));
   endtask

   // active low one hot for digit states, all off in blank slots
   function automatic logic [2:0] sel_for(input qa7_pkg::hsel_t st);
      return (st < qa7_pkg::DIGITS) ? ~(3'b001 << st) : 3'b111;
   endfunction

   // cycles up to and including the next us strobe
   task automatic wait_us(output int cycles);
      cycles = 0;
      do
      begin
         @(negedge sys_clk_p);
         cycles++;
      end
      while (!us_tick && cycles < 2 * qa7_pkg::CLK_PER_US);
      if (!us_tick)
         abort_run("timeout, us_tick did not arrive");
   endtask

   // next ms strobe, scan model steps with it
   task automatic wait_ms(output int cycles);
      cycles = 0;
      do
      begin
         @(negedge sys_clk_p);
         cycles++;
      end
      while (!ms_tick && cycles < MS_CYCLES + 100);
      if (!ms_tick)
         abort_run("timeout, ms_tick did not arrive");
      else if (!us_tick)
         abort_run("ms_tick arrived without a us_tick in the same cycle");
      else
         scan_exp = (scan_exp == 0) ? qa7_pkg::hsel_t'(qa7_pkg::SCAN_LAST) : scan_exp - 1'b1;
   endtask

   task automatic press_button(input int idx, int low_ms, int high_ms);
      int cyc;
      button[idx] = 1'b0;
      repeat (low_ms) wait_ms(cyc);
      button[idx] = 1'b1;                           // release, debounced too
      repeat (high_ms) wait_ms(cyc);
   endtask

   initial
   begin
      void'($urandom(seed));
      sys_clk_p = 1'b0;
      reset     = 1'b1;
      button    = 3'b111;
      hex_value = 12'h8A5;
      tab_val[0] = 12'h000;
      tab_val[1] = 12'hFED;
      tab_val[2] = 12'h8A5;
      for (int k = 3; k < NUM_ENTRIES; k++)
         tab_val[k] = 12'($urandom());
      for (int k = 0; k < NUM_ENTRIES; k++)
         for (int d = 0; d < 3; d++)
            tab_seg[k][d] = font[tab_val[k][4*d +: 4]];
      repeat (10) @(negedge sys_clk_p);
      check_led("led after reset", 2'b00, led);
      check_sel("hsel after reset", 3'b110, hsel);
      check_seg("hex after reset", ~font[hex_value[3:0]], hex);
      check_led("ticks quiet in reset", 2'b00, {us_tick, ms_tick});
      reset = 1'b0;
      wait_us(n);                                   // por stretch, then prescaler
      check_count("first us_tick", qa7_pkg::POR_CYCLES + qa7_pkg::CLK_PER_US, n, 2);
      repeat (2)
      begin
         wait_us(n);
         check_count("us_tick spacing", qa7_pkg::CLK_PER_US, n, 0);
      end
      wait_ms(n);
      wait_ms(n);
      check_count("ms_tick spacing", MS_CYCLES, n, 0);
      for (int k = 0; k < NUM_ENTRIES; k++)
      begin
         hex_value = tab_val[k];
         repeat (qa7_pkg::SCAN_LAST + 1)            // one full scan round
         begin
            wait_ms(n);
            @(negedge sys_clk_p);                   // state has stepped
            check_sel($sformatf("entry %0d hsel st %0d", k, scan_exp), sel_for(scan_exp), hsel);
            check_seg($sformatf("entry %0d hex st %0d", k, scan_exp),
                      (scan_exp < 3) ? ~tab_seg[k][scan_exp] : 8'hFF, hex);
         end
      end
      for (int b = 1; b <= 2; b++)
      begin
         press_button(b, 4, 4);
         check_led($sformatf("button %0d first press", b), 2'(1 << (b - 1)), led);
         press_button(b, 4, 4);
         check_led($sformatf("button %0d second press", b), 2'b00, led);
      end
      wait_ms(n);
      repeat (100) wait_us(n);                      // well clear of the sample
      button[2] = 1'b0;
      repeat (200) wait_us(n);
      button[2] = 1'b1;
      repeat (3) wait_ms(n);
      check_led("short glitch on button 2", 2'b00, led);
      press_button(1, 4, 4);
      check_led("led[0] set before reset button", 2'b01, led);
      while (scan_exp != 3)
         wait_ms(n);
      @(negedge sys_clk_p);
      check_sel("blank slot 3", 3'b111, hsel);
      button[0] = 1'b0;
      repeat (10) @(negedge sys_clk_p);
      button[0] = 1'b1;
      scan_exp = '0;
      check_sel("hsel after reset button", 3'b110, hsel);
      wait_us(n);                                   // two sync flops then prescaler
      check_count("us_tick after reset button", qa7_pkg::CLK_PER_US + 2, n, 2);
      wait_us(n);
      check_count("us_tick spacing after restart", qa7_pkg::CLK_PER_US, n, 0);
      check_led("leds kept over reset button", 2'b01, led);
      $display("STATUS: PASS");
      $finish;
   end

endmodule

`default_nettype wire

// ==== vlog.f ====
rtl/qa7_pkg.sv
rtl/sys_bus_if.sv
rtl/reset_ctl.sv
rtl/tick_gen.sv
rtl/button_toggle.sv
rtl/seg_scan.sv
rtl/qa7_top.sv
dv/tb_qa7_top.sv
